// File: filelist.f
verilog/sprite_pkg.sv
verilog/sprite_ram.sv
verilog/sprite_attr_table.sv
verilog/sprite_renderer.sv
verilog/scanline_buffer.sv
verilog/sprite_engine_top.sv
verif/sprite_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
	--top-module sprite_engine_tb -o sim_sprite_engine
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_sprite_engine)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// File: verif/sprite_engine_tb.sv
`timescale 1ns/1ns

module sprite_engine_tb;

	import sprite_pkg::*;

	localparam int BUSY_TIMEOUT = 8000;

	logic               CLK;
	logic               RSTb;
	cfg_wr_t            cfg;
	logic               line_start;
	logic [COORD_W-1:0] render_y;
	logic [COORD_W-1:0] display_x;
	logic [COLOR_W-1:0] color_index;
	mem_req_t           mem_req;
	logic               mem_ready;
	logic [WORD_W-1:0]  mem_data;
	logic               render_busy;

	int          errors;
	int          checks;
	logic [31:0] lcg_state;
	bit          stall_en;
	bit          log_en;

	logic [MEM_ADDR_W-1:0] req_log[$];
	logic [MEM_ADDR_W-1:0] transparent_q[$];
	logic [COLOR_W-1:0]    exp_line [LINE_WIDTH];
	logic [COLOR_W-1:0]    got_line [LINE_WIDTH];

	sprite_engine_top UUT (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.cfg         (cfg),
		.line_start  (line_start),
		.render_y    (render_y),
		.display_x   (display_x),
		.color_index (color_index),
		.mem_req     (mem_req),
		.mem_ready   (mem_ready),
		.mem_data    (mem_data),
		.render_busy (render_busy)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#20 CLK = ~CLK;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Nibble i of a sheet word is addr[3:0] + i with zero shown as one
	function automatic logic [WORD_W-1:0] sheet_word(input logic [MEM_ADDR_W-1:0] addr);
		logic [WORD_W-1:0] word;
		logic [3:0]        nib;
		word = '0;
		foreach (transparent_q[i]) begin
			if (transparent_q[i] == addr) begin
				return '0;
			end
		end
		for (int i = 0; i < 4; i++) begin
			nib = addr[3:0] + 4'(i);
			word[4*i +: 4] = (nib == 4'd0) ? 4'd1 : nib;
		end
		return word;
	endfunction

	// Sheet memory answers after 0 to 3 idle cycles
	initial begin
		int wait_left;
		bit pending;
		mem_ready = 1'b0;
		mem_data  = '0;
		pending   = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge CLK);
			#2;
			if (mem_ready) begin
				mem_ready = 1'b0;
				pending   = 1'b0;
			end else if (!mem_req.valid) begin
				pending = 1'b0;
			end else begin
				if (!pending) begin
					pending   = 1'b1;
					wait_left = stall_en ? int'(lcg_next() >> 30) : 0;
				end
				if (wait_left == 0) begin
					mem_ready = 1'b1;
					mem_data  = sheet_word(mem_req.addr);
					if (log_en) begin
						req_log.push_back(mem_req.addr);
					end
				end else begin
					wait_left--;
				end
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
		end
	endtask

	task automatic step_cycle();
		@(posedge CLK);
		#2;
	endtask

	function automatic sprite_attr_t make_sprite(input logic [COORD_W-1:0] x,
			input logic [3:0] palette, input logic wide, input logic [COORD_W-1:0] y_top,
			input logic [5:0] width, input logic [COORD_W-1:0] y_bottom,
			input logic [MEM_ADDR_W-1:0] base);
		sprite_attr_t s;
		s.x        = x;
		s.enable   = 1'b1;
		s.palette  = palette;
		s.wide     = wide;
		s.y_top    = y_top;
		s.width    = width;
		s.y_bottom = y_bottom;
		s.base     = base;
		return s;
	endfunction

	task automatic write_word(input logic [1:0] tbl, input int idx, input logic [15:0] data);
		cfg.wr   = 1'b1;
		cfg.addr = {tbl, 8'(idx)};
		cfg.data = data;
		step_cycle();
		cfg.wr   = 1'b0;
	endtask

	task automatic write_attr(input int idx, input sprite_attr_t s);
		write_word(TBL_X, idx, {s.wide, s.palette, s.enable, s.x});
		write_word(TBL_Y, idx, {s.width, s.y_top});
		write_word(TBL_H, idx, {6'd0, s.y_bottom});
		write_word(TBL_A, idx, s.base);
	endtask

	task automatic clear_all();
		for (int i = 0; i < SPRITE_COUNT; i++) begin
			write_word(TBL_X, i, 16'h0000);
		end
	endtask

	// Render into the back buffer and swap so the line can be read
	task automatic render_line(input int y);
		int cycles;
		render_y   = 10'(y);
		req_log.delete();
		line_start = 1'b1;
		step_cycle();
		line_start = 1'b0;
		log_en     = 1'b1;
		cycles     = 0;
		while (render_busy && cycles < BUSY_TIMEOUT) begin
			step_cycle();
			cycles++;
		end
		log_en = 1'b0;
		if (render_busy) begin
			errors++;
			$display("ERROR: render_busy still high %0d cycles into line %0d", cycles, y);
		end
		line_start = 1'b1;
		step_cycle();
		line_start = 1'b0;
	endtask

	task automatic read_pixel(input int x, output logic [COLOR_W-1:0] color);
		display_x = 10'(x);
		step_cycle();
		color = color_index;
	endtask

	task automatic read_line();
		for (int x = 0; x < LINE_WIDTH; x++) begin
			read_pixel(x, got_line[x]);
		end
	endtask

	task automatic clear_expected();
		for (int x = 0; x < LINE_WIDTH; x++) begin
			exp_line[x] = '0;
		end
	endtask

	// Expected pixels of one sprite painted over what is already there
	task automatic paint_sprite(input sprite_attr_t s, input int y);
		int                nib_addr;
		int                px;
		logic [WORD_W-1:0] word;
		logic [3:0]        nib;
		if (s.enable && y >= s.y_top && y <= s.y_bottom) begin
			for (int u = 0; u <= int'(s.width); u++) begin
				nib_addr = int'(s.base) * 4 + (y - int'(s.y_top)) *
					(s.wide ? STRIDE_WIDE : STRIDE_NARROW) + u;
				word = sheet_word(MEM_ADDR_W'(nib_addr >> 2));
				nib  = word[4 * (nib_addr % 4) +: 4];
				px   = int'(s.x) + u;
				if (nib != 4'd0 && px < LINE_WIDTH) begin
					exp_line[px] = {s.palette, nib};
				end
			end
		end
	endtask

	task automatic check_requests(input sprite_attr_t s, input int y);
		int count;
		int nib_addr;
		count = 0;
		if (s.enable && y >= s.y_top && y <= s.y_bottom) begin
			count = int'(s.width) / 4 + 1;
		end
		check_value("mem_req count", count, req_log.size());
		for (int k = 0; k < count && k < req_log.size(); k++) begin
			nib_addr = int'(s.base) * 4 + (y - int'(s.y_top)) *
				(s.wide ? STRIDE_WIDE : STRIDE_NARROW) + 4 * k;
			check_value($sformatf("mem_req.addr[%0d]", k), MEM_ADDR_W'(nib_addr >> 2),
				req_log[k]);
		end
	endtask

	task automatic compare_line();
		for (int x = 0; x < LINE_WIDTH; x++) begin
			check_value($sformatf("color_index[%0d]", x), exp_line[x], got_line[x]);
		end
	endtask

	task automatic reset_state();
		check_value("mem_req.valid", 0, mem_req.valid);
		check_value("render_busy", 0, render_busy);
		clear_all();
		// Line RAM powers up unknown so the first pass only clears it
		render_line(0);
		read_line();
		render_line(0);
		read_line();
		clear_expected();
		compare_line();
	endtask

	task automatic draw_single_sprite();
		sprite_attr_t s;
		clear_all();
		s = make_sprite(10'd100, 4'hA, 1'b0, 10'd20, 6'd13, 10'd40, 16'h0123);
		write_attr(5, s);
		render_line(25);
		check_requests(s, 25);
		read_line();
		clear_expected();
		paint_sprite(s, 25);
		compare_line();
		// Same slot with the wide stride
		s = make_sprite(10'd700, 4'h6, 1'b1, 10'd30, 6'd5, 10'd35, 16'h0F00);
		write_attr(5, s);
		render_line(33);
		check_requests(s, 33);
		read_line();
		clear_expected();
		paint_sprite(s, 33);
		compare_line();
	endtask

	task automatic sweep_vertical_range();
		sprite_attr_t s;
		clear_all();
		s = make_sprite(10'd300, 4'h2, 1'b0, 10'd50, 6'd7, 10'd52, 16'h0400);
		write_attr(7, s);
		// Pixels repeat on every row so only the fetch address shows v
		for (int y = 49; y <= 53; y++) begin
			render_line(y);
			check_requests(s, y);
			read_line();
			clear_expected();
			paint_sprite(s, y);
			compare_line();
		end
		s.enable = 1'b0;
		write_attr(7, s);
		render_line(51);
		check_requests(s, 51);
		read_line();
		clear_expected();
		compare_line();
	endtask

	task automatic overlap_priority();
		sprite_attr_t lo;
		sprite_attr_t hi;
		clear_all();
		lo = make_sprite(10'd200, 4'h3, 1'b0, 10'd60, 6'd15, 10'd60, 16'h1000);
		hi = make_sprite(10'd208, 4'h9, 1'b1, 10'd60, 6'd15, 10'd60, 16'h2000);
		// Second word of the upper sprite is see-through
		transparent_q.push_back(16'h2001);
		write_attr(10, lo);
		write_attr(11, hi);
		render_line(60);
		read_line();
		clear_expected();
		paint_sprite(lo, 60);
		paint_sprite(hi, 60);
		compare_line();
		check_value("palette at x=208", 4'h9, got_line[208][7:4]);
		check_value("palette at x=212", 4'h3, got_line[212][7:4]);
		transparent_q.delete();
	endtask

	task automatic clear_and_stall();
		sprite_attr_t s;
		sprite_attr_t t;
		clear_all();
		s = make_sprite(10'd400, 4'h5, 1'b1, 10'd0, 6'd63, 10'd10, 16'h3456);
		t = make_sprite(10'd420, 4'hC, 1'b0, 10'd0, 6'd20, 10'd10, 16'h0077);
		write_attr(3, s);
		write_attr(4, t);
		clear_expected();
		paint_sprite(s, 4);
		paint_sprite(t, 4);
		stall_en = 1'b0;
		render_line(4);
		read_line();
		compare_line();
		stall_en = 1'b1;
		render_line(4);
		read_line();
		for (int x = 0; x < LINE_WIDTH; x++) begin
			check_value($sformatf("stalled color_index[%0d]", x), exp_line[x], got_line[x]);
		end
		// Buffer was read so an empty line comes back blank
		clear_all();
		render_line(4);
		read_line();
		clear_expected();
		compare_line();
	endtask

	initial begin
		RSTb       = 1'b0;
		cfg        = '0;
		line_start = 1'b0;
		render_y   = '0;
		display_x  = '0;
		errors     = 0;
		checks     = 0;
		lcg_state  = 32'h3cb1_8ccb;
		stall_en   = 1'b1;
		log_en     = 1'b0;
		repeat (5) @(posedge CLK);
		#2;
		RSTb = 1'b1;
		step_cycle();

		reset_state();
		draw_single_sprite();
		sweep_vertical_range();
		overlap_priority();
		clear_and_stall();

		$display("Sprite engine testbench: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/scanline_buffer.sv
`timescale 1ns/1ns

module scanline_buffer (
	input  logic                           CLK,
	input  logic                           RSTb,
	input  logic                           line_start,
	input  sprite_pkg::pix_wr_t            pix_wr,
	input  logic [sprite_pkg::COORD_W-1:0] display_x,
	output logic [sprite_pkg::COLOR_W-1:0] color_index
);

	import sprite_pkg::*;

	// Buffer the renderer writes into
	logic               back_sel;
	// Buffer that served the previous read
	logic               rd_sel_q;
	logic               clr_en;
	logic [COORD_W-1:0] rd_addr_q;
	logic [COLOR_W-1:0] rd_data [2];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			back_sel <= 1'b0;
			rd_sel_q <= 1'b1;
			clr_en   <= 1'b0;
		end else begin
			if (line_start) begin
				back_sel <= ~back_sel;
			end
			rd_sel_q <= ~back_sel;
			clr_en   <= 1'b1;
		end
	end

	// Column to be cleared one cycle after its read
	always_ff @(posedge CLK) begin
		rd_addr_q <= display_x;
	end

	genvar b;
	generate
		for (b = 0; b < 2; b++) begin : g_buf
			logic               pix_hit;
			logic               clr_hit;
			logic [COORD_W-1:0] wr_addr;
			logic [COLOR_W-1:0] wr_data;

			assign pix_hit = pix_wr.wr && (back_sel == 1'(b));
			assign clr_hit = clr_en && (rd_sel_q == 1'(b));

			// Renderer wins on the one cycle after a swap
			assign wr_addr = pix_hit ? pix_wr.x : rd_addr_q;
			assign wr_data = pix_hit ? pix_wr.color : COLOR_W'(0);

			sprite_ram #(
				.WIDTH   (COLOR_W),
				.DEPTH_W (COORD_W)
			) u_ram (
				.CLK     (CLK),
				.rd_addr (display_x),
				.rd_data (rd_data[b]),
				.wr_addr (wr_addr),
				.wr_en   (pix_hit || clr_hit),
				.wr_data (wr_data)
			);
		end
	endgenerate

	assign color_index = rd_data[rd_sel_q];

endmodule

// File: verilog/sprite_attr_table.sv
`timescale 1ns/1ns

module sprite_attr_table (
	input  logic                                CLK,
	input  sprite_pkg::cfg_wr_t                 cfg,
	input  logic [sprite_pkg::SPRITE_IDX_W-1:0] sprite_idx,
	output sprite_pkg::sprite_attr_t            attr
);

	import sprite_pkg::*;

	logic [1:0]        tbl_sel;
	logic [WORD_W-1:0] tbl_word [4];

	// Top address bits pick the table, low bits the sprite
	assign tbl_sel = cfg.addr[CFG_ADDR_W-1 -: 2];

	genvar t;
	generate
		for (t = 0; t < 4; t++) begin : g_tbl
			logic tbl_wr;

			assign tbl_wr = cfg.wr && (tbl_sel == 2'(t));

			sprite_ram #(
				.WIDTH   (WORD_W),
				.DEPTH_W (SPRITE_IDX_W)
			) u_ram (
				.CLK     (CLK),
				.rd_addr (sprite_idx),
				.rd_data (tbl_word[t]),
				.wr_addr (cfg.addr[SPRITE_IDX_W-1:0]),
				.wr_en   (tbl_wr),
				.wr_data (cfg.data)
			);
		end
	endgenerate

	// Field layout of the four words
	always_comb begin
		// X word
		attr.x        = tbl_word[TBL_X][9:0];
		attr.enable   = tbl_word[TBL_X][10];
		attr.palette  = tbl_word[TBL_X][14:11];
		attr.wide     = tbl_word[TBL_X][15];

		// Y word
		attr.y_top    = tbl_word[TBL_Y][9:0];
		attr.width    = tbl_word[TBL_Y][15:10];

		// H word, upper bits reserved
		attr.y_bottom = tbl_word[TBL_H][9:0];

		// A word, sheet base in words
		attr.base     = tbl_word[TBL_A];
	end

endmodule

// File: verilog/sprite_engine_top.sv
`timescale 1ns/1ns

module sprite_engine_top (
	input  logic                           CLK,
	input  logic                           RSTb,
	input  sprite_pkg::cfg_wr_t            cfg,
	input  logic                           line_start,
	input  logic [sprite_pkg::COORD_W-1:0] render_y,
	input  logic [sprite_pkg::COORD_W-1:0] display_x,
	output logic [sprite_pkg::COLOR_W-1:0] color_index,
	output sprite_pkg::mem_req_t           mem_req,
	input  logic                           mem_ready,
	input  logic [sprite_pkg::WORD_W-1:0]  mem_data,
	output logic                           render_busy
);

	import sprite_pkg::*;

	logic [SPRITE_IDX_W-1:0] sprite_idx;
	sprite_attr_t            attr;
	pix_wr_t                 pix_wr;

	sprite_attr_table u_attr_table (
		.CLK        (CLK),
		.cfg        (cfg),
		.sprite_idx (sprite_idx),
		.attr       (attr)
	);

	sprite_renderer u_renderer (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.line_start  (line_start),
		.render_y    (render_y),
		.attr        (attr),
		.sprite_idx  (sprite_idx),
		.mem_req     (mem_req),
		.mem_ready   (mem_ready),
		.mem_data    (mem_data),
		.pix_wr      (pix_wr),
		.render_busy (render_busy)
	);

	// Display side reads the front buffer
	scanline_buffer u_line_buf (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.line_start  (line_start),
		.pix_wr      (pix_wr),
		.display_x   (display_x),
		.color_index (color_index)
	);

endmodule

// File: verilog/sprite_pkg.sv
package sprite_pkg;

	// Sprite table geometry
	localparam int SPRITE_COUNT = 256;
	localparam int SPRITE_IDX_W = 8;

	// Line geometry
	localparam int LINE_WIDTH = 800;
	localparam int COORD_W    = 10;
	localparam int COLOR_W    = 8;

	// Host register port, 16-bit words
	localparam int CFG_ADDR_W = 10;
	localparam int WORD_W     = 16;

	// Table select in the top two register address bits
	localparam logic [1:0] TBL_X = 2'd0;
	localparam logic [1:0] TBL_Y = 2'd1;
	localparam logic [1:0] TBL_H = 2'd2;
	localparam logic [1:0] TBL_A = 2'd3;

	// Sprite sheet memory
	localparam int MEM_ADDR_W    = 16;
	localparam int NIBBLE_ADDR_W = 18;
	localparam int STRIDE_NARROW = 128;
	localparam int STRIDE_WIDE   = 256;

	typedef struct packed {
		logic                  wr;
		logic [CFG_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     data;
	} cfg_wr_t;

	typedef struct packed {
		logic [COORD_W-1:0]    x;
		logic                  enable;
		logic [3:0]            palette;
		logic                  wide;
		logic [COORD_W-1:0]    y_top;
		// Offset of the last pixel, not the pixel count
		logic [5:0]            width;
		logic [COORD_W-1:0]    y_bottom;
		logic [MEM_ADDR_W-1:0] base;
	} sprite_attr_t;

	typedef struct packed {
		logic                  valid;
		logic [MEM_ADDR_W-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic               wr;
		logic [COORD_W-1:0] x;
		logic [COLOR_W-1:0] color;
	} pix_wr_t;

endpackage

// File: verilog/sprite_ram.sv
`timescale 1ns/1ns

module sprite_ram #(
	parameter int WIDTH   = 16,
	parameter int DEPTH_W = 8
) (
	input  logic               CLK,
	input  logic [DEPTH_W-1:0] rd_addr,
	output logic [WIDTH-1:0]   rd_data,
	input  logic [DEPTH_W-1:0] wr_addr,
	input  logic               wr_en,
	input  logic [WIDTH-1:0]   wr_data
);

	logic [WIDTH-1:0] mem [2**DEPTH_W];

	// Read returns the old contents on a same-address write
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

// File: verilog/sprite_renderer.sv
`timescale 1ns/1ns

module sprite_renderer (
	input  logic                                CLK,
	input  logic                                RSTb,
	input  logic                                line_start,
	input  logic [sprite_pkg::COORD_W-1:0]      render_y,
	input  sprite_pkg::sprite_attr_t            attr,
	output logic [sprite_pkg::SPRITE_IDX_W-1:0] sprite_idx,
	output sprite_pkg::mem_req_t                mem_req,
	input  logic                                mem_ready,
	input  logic [sprite_pkg::WORD_W-1:0]       mem_data,
	output sprite_pkg::pix_wr_t                 pix_wr,
	output logic                                render_busy
);

	import sprite_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_BEGIN,
		S_LOAD,
		S_ADDR,
		S_FETCH,
		S_BLIT,
		S_FINISH
	} state_t;

	// Control state
	state_t                  state, state_next;
	logic [SPRITE_IDX_W-1:0] idx, idx_next;
	logic                    req_valid, req_valid_next;
	logic                    pix_strobe, pix_strobe_next;

	// Payload
	logic [MEM_ADDR_W-1:0]   req_addr, req_addr_next;
	logic [COORD_W-1:0]      v, v_next;
	logic [5:0]              u, u_next;
	logic [WORD_W-1:0]       word_q, word_next;
	logic [COORD_W-1:0]      pix_x_q, pix_x_next;
	logic [COLOR_W-1:0]      pix_color_q, pix_color_next;

	logic                     in_range;
	logic                     last_sprite;
	logic [NIBBLE_ADDR_W-1:0] row_off;
	logic [NIBBLE_ADDR_W-1:0] nib_addr;
	logic [3:0]               cur_nib;
	logic [COORD_W:0]         pix_x;

	assign in_range = attr.enable && (render_y >= attr.y_top) && (render_y <= attr.y_bottom);
	assign last_sprite = (idx == SPRITE_IDX_W'(SPRITE_COUNT - 1));

	// Sheet rows are a power of two in nibbles
	assign row_off = attr.wide ? NIBBLE_ADDR_W'(v) * NIBBLE_ADDR_W'(STRIDE_WIDE)
	                           : NIBBLE_ADDR_W'(v) * NIBBLE_ADDR_W'(STRIDE_NARROW);
	assign nib_addr = {attr.base, 2'b00} + row_off + NIBBLE_ADDR_W'(u);

	// Lowest nibble of the word is the leftmost pixel
	assign cur_nib = word_q[{u[1:0], 2'b00} +: 4];

	// One spare bit so pixels past the right edge can be dropped
	assign pix_x = {1'b0, attr.x} + (COORD_W + 1)'(u);

	always_comb begin
		state_next      = state;
		idx_next        = idx;
		req_valid_next  = req_valid;
		req_addr_next   = req_addr;
		v_next          = v;
		u_next          = u;
		word_next       = word_q;
		pix_strobe_next = 1'b0;
		pix_x_next      = pix_x_q;
		pix_color_next  = pix_color_q;

		if (line_start) begin
			// New line, abandon whatever was in flight
			state_next     = S_BEGIN;
			idx_next       = '0;
			req_valid_next = 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
				end
				S_BEGIN: begin
					// Table read in progress
					state_next = S_LOAD;
				end
				S_LOAD: begin
					u_next = '0;
					v_next = render_y - attr.y_top;
					if (in_range) begin
						state_next = S_ADDR;
					end else if (last_sprite) begin
						state_next = S_IDLE;
					end else begin
						idx_next   = idx + 1'b1;
						state_next = S_BEGIN;
					end
				end
				S_ADDR: begin
					req_valid_next = 1'b1;
					req_addr_next  = nib_addr[NIBBLE_ADDR_W-1:2];
					state_next     = S_FETCH;
				end
				S_FETCH: begin
					// Address held until the memory accepts
					if (mem_ready) begin
						req_valid_next = 1'b0;
						word_next      = mem_data;
						state_next     = S_BLIT;
					end
				end
				S_BLIT: begin
					// Zero nibbles are transparent
					pix_strobe_next = (cur_nib != 4'd0) && (pix_x < (COORD_W + 1)'(LINE_WIDTH));
					pix_x_next      = pix_x[COORD_W-1:0];
					pix_color_next  = {attr.palette, cur_nib};
					if (u == attr.width) begin
						state_next = S_FINISH;
					end else begin
						u_next = u + 1'b1;
						if (u[1:0] == 2'd3) begin
							state_next = S_ADDR;
						end
					end
				end
				S_FINISH: begin
					if (last_sprite) begin
						state_next = S_IDLE;
					end else begin
						idx_next   = idx + 1'b1;
						state_next = S_BEGIN;
					end
				end
				default: begin
					state_next = S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state      <= S_IDLE;
			idx        <= '0;
			req_valid  <= 1'b0;
			pix_strobe <= 1'b0;
		end else begin
			state      <= state_next;
			idx        <= idx_next;
			req_valid  <= req_valid_next;
			pix_strobe <= pix_strobe_next;
		end
	end

	always_ff @(posedge CLK) begin
		req_addr    <= req_addr_next;
		v           <= v_next;
		u           <= u_next;
		word_q      <= word_next;
		pix_x_q     <= pix_x_next;
		pix_color_q <= pix_color_next;
	end

	assign sprite_idx  = idx;
	assign render_busy = (state != S_IDLE);
	assign mem_req     = '{valid: req_valid, addr: req_addr};
	assign pix_wr      = '{wr: pix_strobe, x: pix_x_q, color: pix_color_q};

endmodule
